// ==== dv/dcache_golden.txt ====
// op addr wstrb wdata exp_rdata exp_miss exp_wb
// op 0 load, 1 store, f ends the list; exp_rdata is checked for loads only
0 00001024 0 00000000 5A5A1024 1 0
0 00001030 0 00000000 5A5A1030 0 0
0 0000103C 0 00000000 5A5A103C 0 0
1 00001030 5 AABBCCDD 00000000 0 0
0 00001030 0 00000000 5ABB10DD 0 0
0 00001220 0 00000000 5A5A1220 1 0
0 00001024 0 00000000 5A5A1024 0 0
0 0000122C 0 00000000 5A5A122C 0 0
0 00001028 0 00000000 5A5A1028 0 0
0 00001420 0 00000000 5A5A1420 1 0
0 00001034 0 00000000 5A5A1034 0 0
0 00001220 0 00000000 5A5A1220 1 0
0 00001620 0 00000000 5A5A1620 1 1
0 00001030 0 00000000 5ABB10DD 1 0
1 00000048 3 1234BEEF 00000000 1 0
0 00000048 0 00000000 5A5ABEEF 0 0
1 0000004C C CAFE0000 00000000 0 0
0 0000004C 0 00000000 CAFE004C 0 0
0 00000448 0 00000000 5A5A0448 1 0
0 00000848 0 00000000 5A5A0848 1 1
0 0000004C 0 00000000 CAFE004C 1 0
0 00000048 0 00000000 5A5ABEEF 0 0
0 0000085C 0 00000000 5A5A085C 0 0
f 00000000 0 00000000 00000000 0 0

// ==== dv/mem_model.sv ====
module mem_model
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  rd_req_i,
    input  addr_t rd_addr_i,
    output logic  rd_rdy_o,
    output logic  ret_valid_o,
    output line_t ret_data_o,
    input  logic  wr_req_i,
    input  addr_t wr_addr_i,
    input  line_t wr_data_i,
    output logic  wr_rdy_o
);

    localparam logic [2:0] M_IDLE   = 3'd0;
    localparam logic [2:0] M_RD_ACK = 3'd1;
    localparam logic [2:0] M_RD_RET = 3'd2;
    localparam logic [2:0] M_WR_ACK = 3'd3;
    localparam logic [2:0] M_WR_GAP = 3'd4;  // wr_req still high for one cycle

    word_t      mem [addr_t];   // only words that were written back
    integer     seed = 38;
    logic [2:0] phase;
    logic [1:0] delay;
    addr_t      line_addr;
    int         w;

    function automatic line_t read_line(input addr_t base);
        line_t l;
        addr_t a;
        int    k;
        for (k = 0; k < LINE_WORDS; k++) begin
            a = base + addr_t'(4 * k);
            l[k] = mem.exists(a) ? mem[a] : (a ^ 32'h5A5A_0000);
        end
        return l;
    endfunction

    initial begin
        rd_rdy_o    = 1'b0;
        ret_valid_o = 1'b0;
        ret_data_o  = '0;
        wr_rdy_o    = 1'b0;
        phase       = M_IDLE;
        delay       = 2'd0;
    end

    always @(posedge clk) begin
        rd_rdy_o    <= 1'b0;
        ret_valid_o <= 1'b0;
        wr_rdy_o    <= 1'b0;
        if (reset) begin
            phase <= M_IDLE;
        end else begin
            case (phase)
                M_IDLE: begin
                    delay <= 2'($random(seed));
                    if (rd_req_i) begin
                        line_addr <= rd_addr_i;
                        phase     <= M_RD_ACK;
                    end else if (wr_req_i) begin
                        phase <= M_WR_ACK;
                    end
                end
                M_RD_ACK: begin
                    if (delay == 2'd0) begin
                        rd_rdy_o <= 1'b1;
                        delay    <= 2'($random(seed));
                        phase    <= M_RD_RET;
                    end else begin
                        delay <= delay - 2'd1;
                    end
                end
                M_RD_RET: begin
                    if (delay == 2'd0) begin
                        ret_valid_o <= 1'b1;
                        ret_data_o  <= read_line(line_addr);
                        phase       <= M_IDLE;
                    end else begin
                        delay <= delay - 2'd1;
                    end
                end
                M_WR_ACK: begin
                    if (delay == 2'd0) begin
                        for (w = 0; w < LINE_WORDS; w++) begin
                            mem[wr_addr_i + addr_t'(4 * w)] = wr_data_i[w];
                        end
                        wr_rdy_o <= 1'b1;
                        phase    <= M_WR_GAP;
                    end else begin
                        delay <= delay - 2'd1;
                    end
                end
                default: phase <= M_IDLE;
            endcase
        end
    end

endmodule

// ==== dv/tb_dcache.sv ====
module tb_dcache
    import dcache_pkg::*;
();

    localparam int COLS    = 7;     // op addr wstrb wdata rdata miss wb
    localparam int MAX_REQ = 64;
    localparam int TIMEOUT = 200;
    localparam int SETS    = 16;
    localparam int IDX_W   = $clog2(SETS);

    logic  clk = 1'b0;
    logic  reset;
    logic  valid_i, op_i, addr_ok_o, data_ok_o, miss_o;
    addr_t addr_i, rd_addr_o, wr_addr_o;
    strb_t wstrb_i;
    word_t wdata_i, rdata_o;
    logic  rd_req_o, rd_rdy_i, ret_valid_i, wr_req_o, wr_rdy_i;
    line_t ret_data_i, wr_data_o;

    logic [31:0] golden [MAX_REQ*COLS];
    word_t       shadow [addr_t];       // memory as the cpu should see it
    logic        dirty_lines [addr_t];  // line bases stored to and not yet written back
    int          pend_q [$];            // accepted and waiting for data_ok
    int          acc_cyc [MAX_REQ];
    int          cyc;
    int          done_cnt = 0;
    int          n_req;
    logic        wb_seen = 1'b0;

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= reset ? 0 : cyc + 1;
    end

    dcache_top #(.SETS(SETS)) UUT (
        .clk         (clk),
        .reset       (reset),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .wstrb_i     (wstrb_i),
        .wdata_i     (wdata_i),
        .addr_ok_o   (addr_ok_o),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o),
        .miss_o      (miss_o),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .rd_rdy_i    (rd_rdy_i),
        .ret_valid_i (ret_valid_i),
        .ret_data_i  (ret_data_i),
        .wr_req_o    (wr_req_o),
        .wr_addr_o   (wr_addr_o),
        .wr_data_o   (wr_data_o),
        .wr_rdy_i    (wr_rdy_i)
    );

    mem_model mem_u (
        .clk         (clk),
        .reset       (reset),
        .rd_req_i    (rd_req_o),
        .rd_addr_i   (rd_addr_o),
        .rd_rdy_o    (rd_rdy_i),
        .ret_valid_o (ret_valid_i),
        .ret_data_o  (ret_data_i),
        .wr_req_i    (wr_req_o),
        .wr_addr_i   (wr_addr_o),
        .wr_data_i   (wr_data_o),
        .wr_rdy_o    (wr_rdy_i)
    );

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    function automatic word_t shadow_word(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'h5A5A_0000; // untouched memory fill
    endfunction

    function automatic line_t shadow_line(input addr_t base);
        line_t l;
        int    w;
        for (w = 0; w < LINE_WORDS; w++) begin
            l[w] = shadow_word(base + addr_t'(4 * w));
        end
        return l;
    endfunction

    function automatic addr_t line_base(input addr_t a);
        return a & ~addr_t'(4 * LINE_WORDS - 1);
    endfunction

    // dirty line sharing the set of the missing request
    function automatic addr_t dirty_victim(input addr_t req);
        addr_t found;
        found = '1;
        foreach (dirty_lines[base]) begin
            if (base[OFFSET_W +: IDX_W] == req[OFFSET_W +: IDX_W] &&
                base != line_base(req)) begin
                found = base;
            end
        end
        return found;
    endfunction

    task automatic note_store(input addr_t a, input strb_t s, input word_t d);
        word_t w;
        int    b;
        w = shadow_word(a);
        for (b = 0; b < 4; b++) begin
            if (s[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        shadow[a] = w;
        dirty_lines[line_base(a)] = 1'b1;
    endtask

    task automatic drive_request(input int idx);
        valid_i <= 1'b1;
        op_i    <= golden[idx*COLS][0];
        addr_i  <= golden[idx*COLS + 1];
        wstrb_i <= golden[idx*COLS + 2][3:0];
        wdata_i <= golden[idx*COLS + 3];
    endtask

    // returns in the cycle whose rising edge takes the request
    task automatic wait_accept(input int idx);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!addr_ok_o) begin
            waited++;
            if (waited >= TIMEOUT) begin
                $display("timeout: request %0d not accepted within %0d cycles", idx, TIMEOUT);
                end_with_failure();
            end
            @(negedge clk);
        end
        acc_cyc[idx] = cyc;
        // a load hit frees the lookup stage in its own completion cycle
        if (idx > 0 && golden[(idx-1)*COLS] == 0 && golden[(idx-1)*COLS + 5] == 0 &&
            acc_cyc[idx] != acc_cyc[idx-1] + 1) begin
            $display("ERROR at %0t: addr_ok_o accept cycle %0d, expected %0d",
                     $time, acc_cyc[idx], acc_cyc[idx-1] + 1);
            end_with_failure();
        end
        if (golden[idx*COLS][0]) begin
            note_store(golden[idx*COLS + 1], golden[idx*COLS + 2][3:0], golden[idx*COLS + 3]);
        end
        pend_q.push_back(idx);
    endtask

    task automatic wait_all_done(input int n);
        int waited;
        waited = 0;
        while (done_cnt < n) begin
            @(posedge clk);
            waited++;
            if (waited >= TIMEOUT) begin
                $display("timeout: only %0d of %0d requests returned data_ok", done_cnt, n);
                end_with_failure();
            end
        end
    endtask

    always @(negedge clk) begin : monitor
        int    idx;
        addr_t miss_addr;
        addr_t exp_wb;
        if (!reset) begin
            if ((rd_req_o && rd_rdy_i) || (wr_req_o && wr_rdy_i)) begin
                if (pend_q.size() == 0) begin
                    $display("memory request issued with no cpu request outstanding");
                    end_with_failure();
                end
                miss_addr = golden[pend_q[0]*COLS + 1];
                if (rd_req_o) begin
                    check_word("rd_addr_o", rd_addr_o, line_base(miss_addr));
                end
                if (wr_req_o) begin
                    exp_wb = dirty_victim(miss_addr);
                    check_word("wr_addr_o", wr_addr_o, exp_wb);
                    check_line("wr_data_o", wr_data_o, shadow_line(exp_wb));
                    dirty_lines.delete(exp_wb);
                    wb_seen = 1'b1;
                end
            end
            if (data_ok_o) begin
                if (pend_q.size() == 0) begin
                    $display("data_ok_o pulsed with no request outstanding");
                    end_with_failure();
                end
                idx = pend_q.pop_front();
                check_flag("miss_o", miss_o, golden[idx*COLS + 5][0]);
                if (!golden[idx*COLS][0]) begin
                    check_word("rdata_o", rdata_o, golden[idx*COLS + 4]);
                end
                check_flag("wr_req_o", wb_seen, golden[idx*COLS + 6][0]);
                if (!golden[idx*COLS + 5][0] && cyc != acc_cyc[idx] + 1) begin
                    $display("ERROR at %0t: data_ok_o latency %0d, expected 1",
                             $time, cyc - acc_cyc[idx]);
                    end_with_failure();
                end
                wb_seen = 1'b0;
                done_cnt++;
            end
        end
    end

    initial begin
        int i;
        reset   = 1'b1;
        valid_i = 1'b0;
        op_i    = 1'b0;
        addr_i  = '0;
        wstrb_i = '0;
        wdata_i = '0;
        $readmemh("dv/dcache_golden.txt", golden);
        n_req = 0;
        while (n_req < MAX_REQ && golden[n_req*COLS] != 32'hf) begin
            n_req++;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("addr_ok_o", addr_ok_o, 1'b1);
        check_flag("data_ok_o", data_ok_o, 1'b0);
        check_flag("miss_o", miss_o, 1'b0);
        check_flag("rd_req_o", rd_req_o, 1'b0);
        check_flag("wr_req_o", wr_req_o, 1'b0);
        @(posedge clk);
        for (i = 0; i < n_req; i++) begin
            drive_request(i);
            wait_accept(i);
            @(posedge clk);
        end
        valid_i <= 1'b0;
        wait_all_done(n_req);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f src.f

result=$(./obj_dir/Vtb_dcache || true)
echo "$result"
if echo "$result" | grep -qF "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// ==== src.f ====
verilog/dcache_pkg.sv
verilog/way_if.sv
verilog/dcache_way.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
dv/mem_model.sv
dv/tb_dcache.sv

// ==== verilog/dcache_ctrl.sv ====
module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int SETS = 16
) (
    input  logic  clk,
    input  logic  reset,

    input  logic  valid_i,
    input  logic  op_i,         // 0 load, 1 store
    input  addr_t addr_i,
    input  strb_t wstrb_i,
    input  word_t wdata_i,
    output logic  addr_ok_o,
    output logic  data_ok_o,
    output word_t rdata_o,
    output logic  miss_o,

    output logic  rd_req_o,
    output addr_t rd_addr_o,
    input  logic  rd_rdy_i,
    input  logic  ret_valid_i,
    input  line_t ret_data_i,

    output logic  wr_req_o,
    output addr_t wr_addr_o,
    output line_t wr_data_o,
    input  logic  wr_rdy_i,

    way_if.ctrl   way0,
    way_if.ctrl   way1
);

    localparam int IDX_W  = $clog2(SETS);
    localparam int TAG_W  = ADDR_W - OFFSET_W - IDX_W;
    localparam int BYTE_W = OFFSET_W - WORD_SEL_W;

    localparam logic [2:0] ST_LOOKUP = 3'd0;
    localparam logic [2:0] ST_WB     = 3'd1;
    localparam logic [2:0] ST_RREQ   = 3'd2;
    localparam logic [2:0] ST_RWAIT  = 3'd3;
    localparam logic [2:0] ST_DONE   = 3'd4;

    logic [2:0] state;

    // lookup stage
    logic  lk_valid;
    logic  lk_op;
    addr_t lk_addr;
    strb_t lk_strb;
    word_t lk_wdata;

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    word_sel_t        lk_sel;

    logic            accept;
    logic            lk_hit;
    logic            lk_miss;
    logic            store_hit;
    logic            refill_fill;
    logic            victim;
    logic            victim_q;
    logic            vic_dirty;
    logic [SETS-1:0] lru_q;     // way touched last in each set
    line_t           hit_line;
    line_t           refill_merged;
    line_t           refill_line;

    assign lk_idx = lk_addr[OFFSET_W +: IDX_W];
    assign lk_tag = lk_addr[ADDR_W-1 -: TAG_W];
    assign lk_sel = lk_addr[BYTE_W +: WORD_SEL_W];

    assign lk_hit    = (state == ST_LOOKUP) && lk_valid && (way0.hit || way1.hit);
    assign lk_miss   = (state == ST_LOOKUP) && lk_valid && !(way0.hit || way1.hit);
    assign store_hit = lk_hit && lk_op;

    // a store hit writes this cycle, so the next read must wait
    assign addr_ok_o = (state == ST_LOOKUP) && (!lk_valid || (lk_hit && !lk_op));
    assign accept    = valid_i && addr_ok_o;

    assign hit_line  = way1.hit ? way1.line : way0.line;
    assign data_ok_o = lk_hit || (state == ST_DONE);
    assign miss_o    = (state == ST_DONE);
    assign rdata_o   = (state == ST_DONE) ? refill_line[lk_sel] : hit_line[lk_sel];

    // invalid way first, else the one not touched last
    always_comb begin
        if (!way0.valid) begin
            victim = 1'b0;
        end else if (!way1.valid) begin
            victim = 1'b1;
        end else begin
            victim = ~lru_q[lk_idx];
        end
    end
    assign vic_dirty = victim ? way1.dirty : way0.dirty;

    always_ff @(posedge clk) begin
        if (reset) begin
            lk_valid <= 1'b0;
        end else if (accept) begin
            lk_valid <= 1'b1;
        end else if (lk_hit || state == ST_DONE) begin
            lk_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lk_op    <= op_i;
            lk_addr  <= addr_i;
            lk_strb  <= wstrb_i;
            lk_wdata <= wdata_i;
        end
        if (lk_miss) begin
            victim_q <= victim;
        end
        if (refill_fill) begin
            refill_line <= refill_merged;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_LOOKUP;
        end else begin
            case (state)
                ST_LOOKUP: if (lk_miss) state <= vic_dirty ? ST_WB : ST_RREQ;
                ST_WB:     if (wr_rdy_i) state <= ST_RREQ;
                ST_RREQ:   if (rd_rdy_i) state <= ST_RWAIT;
                ST_RWAIT:  if (ret_valid_i) state <= ST_DONE;
                default:   state <= ST_LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (lk_hit) begin
            lru_q[lk_idx] <= way1.hit;
        end else if (refill_fill) begin
            lru_q[lk_idx] <= victim_q;
        end
    end

    // memory side
    assign wr_req_o  = (state == ST_WB);
    assign wr_addr_o = {(victim_q ? way1.tag : way0.tag), lk_idx, {OFFSET_W{1'b0}}};
    assign wr_data_o = victim_q ? way1.line : way0.line;
    assign rd_req_o  = (state == ST_RREQ);
    assign rd_addr_o = {lk_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign refill_fill = (state == ST_RWAIT) && ret_valid_i;

    always_comb begin
        refill_merged = ret_data_i;
        if (lk_op) begin
            refill_merged[lk_sel] = merge_word(ret_data_i[lk_sel], lk_wdata, lk_strb);
        end
    end

    // way 0
    assign way0.lk_idx    = accept ? addr_i[OFFSET_W +: IDX_W] : lk_idx;
    assign way0.lk_tag    = lk_tag;
    assign way0.line_we   = refill_fill && !victim_q;
    assign way0.word_we   = store_hit && way0.hit;
    assign way0.wr_idx    = lk_idx;
    assign way0.wr_tag    = lk_tag;
    assign way0.wr_line   = refill_fill ? refill_merged : {LINE_WORDS{lk_wdata}};
    assign way0.wr_sel    = lk_sel;
    assign way0.wr_strb   = lk_strb;
    assign way0.set_dirty = way0.word_we || (way0.line_we && lk_op);
    assign way0.clr_dirty = way0.line_we && !lk_op;

    // way 1
    assign way1.lk_idx    = accept ? addr_i[OFFSET_W +: IDX_W] : lk_idx;
    assign way1.lk_tag    = lk_tag;
    assign way1.line_we   = refill_fill && victim_q;
    assign way1.word_we   = store_hit && way1.hit;
    assign way1.wr_idx    = lk_idx;
    assign way1.wr_tag    = lk_tag;
    assign way1.wr_line   = refill_fill ? refill_merged : {LINE_WORDS{lk_wdata}};
    assign way1.wr_sel    = lk_sel;
    assign way1.wr_strb   = lk_strb;
    assign way1.set_dirty = way1.word_we || (way1.line_we && lk_op);
    assign way1.clr_dirty = way1.line_we && !lk_op;

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(rd_req_o && wr_req_o)
    );

    // a line lives in at most one way
    a_single_hit: assert property (
        @(posedge clk) disable iff (reset)
        lk_valid |-> !(way0.hit && way1.hit)
    );

    a_rd_aligned: assert property (
        @(posedge clk) disable iff (reset)
        rd_req_o |-> (rd_addr_o[OFFSET_W-1:0] == '0)
    );

endmodule

// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    // fixed geometry shared by all modules
    localparam int ADDR_W     = 32;
    localparam int LINE_WORDS = 8;
    localparam int OFFSET_W   = 5;   // byte offset inside a 32-byte line
    localparam int WORD_SEL_W = 3;   // word select inside the line

    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;      // byte enables of one word
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

    // word 0 sits in the low bits
    typedef word_t [LINE_WORDS-1:0] line_t;

    // byte-masked merge of store data into an existing word
    function automatic word_t merge_word(
        input word_t old_w,
        input word_t new_w,
        input strb_t strb
    );
        word_t res;
        int b;
        res = old_w;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

// ==== verilog/dcache_top.sv ====
module dcache_top
    import dcache_pkg::*;
#(
    parameter int SETS = 16
) (
    input  logic  clk,
    input  logic  reset,

    // cpu side
    input  logic  valid_i,
    input  logic  op_i,
    input  addr_t addr_i,
    input  strb_t wstrb_i,
    input  word_t wdata_i,
    output logic  addr_ok_o,
    output logic  data_ok_o,
    output word_t rdata_o,
    output logic  miss_o,

    // memory side
    output logic  rd_req_o,
    output addr_t rd_addr_o,
    input  logic  rd_rdy_i,
    input  logic  ret_valid_i,
    input  line_t ret_data_i,
    output logic  wr_req_o,
    output addr_t wr_addr_o,
    output line_t wr_data_o,
    input  logic  wr_rdy_i
);

    way_if #(.SETS(SETS)) way0_if ();
    way_if #(.SETS(SETS)) way1_if ();

    dcache_way #(.SETS(SETS)) way0_u (
        .clk   (clk),
        .reset (reset),
        .port  (way0_if)
    );

    dcache_way #(.SETS(SETS)) way1_u (
        .clk   (clk),
        .reset (reset),
        .port  (way1_if)
    );

    dcache_ctrl #(.SETS(SETS)) ctrl_u (
        .clk         (clk),
        .reset       (reset),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .wstrb_i     (wstrb_i),
        .wdata_i     (wdata_i),
        .addr_ok_o   (addr_ok_o),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o),
        .miss_o      (miss_o),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .rd_rdy_i    (rd_rdy_i),
        .ret_valid_i (ret_valid_i),
        .ret_data_i  (ret_data_i),
        .wr_req_o    (wr_req_o),
        .wr_addr_o   (wr_addr_o),
        .wr_data_o   (wr_data_o),
        .wr_rdy_i    (wr_rdy_i),
        .way0        (way0_if),
        .way1        (way1_if)
    );

endmodule

// ==== verilog/dcache_way.sv ====
module dcache_way
    import dcache_pkg::*;
#(
    parameter int SETS = 16
) (
    input logic clk,
    input logic reset,
    way_if.way  port
);

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    logic [TAG_W-1:0] tag_mem [SETS];
    line_t            data_mem [SETS];
    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;

    logic [IDX_W-1:0] rd_idx_q;
    logic [TAG_W-1:0] rd_tag_q;
    line_t            rd_line_q;

    // tag and data arrays with synchronous read
    always_ff @(posedge clk) begin
        if (port.line_we) begin
            tag_mem[port.wr_idx]  <= port.wr_tag;
            data_mem[port.wr_idx] <= port.wr_line;
        end else if (port.word_we) begin
            for (int b = 0; b < 4; b++) begin
                if (port.wr_strb[b]) begin
                    data_mem[port.wr_idx][port.wr_sel][b*8 +: 8] <=
                        port.wr_line[port.wr_sel][b*8 +: 8];
                end
            end
        end
        rd_idx_q  <= port.lk_idx;
        rd_tag_q  <= tag_mem[port.lk_idx];
        rd_line_q <= data_mem[port.lk_idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (port.line_we) begin
                valid_q[port.wr_idx] <= 1'b1;
            end
            if (port.set_dirty) begin
                dirty_q[port.wr_idx] <= 1'b1;
            end else if (port.clr_dirty) begin
                dirty_q[port.wr_idx] <= 1'b0;
            end
        end
    end

    // compare against the tag held in the lookup stage
    assign port.valid = valid_q[rd_idx_q];
    assign port.dirty = dirty_q[rd_idx_q];
    assign port.tag   = rd_tag_q;
    assign port.line  = rd_line_q;
    assign port.hit   = valid_q[rd_idx_q] && (rd_tag_q == port.lk_tag);

    // controller must never mix a refill with a store write
    a_one_write_kind: assert property (
        @(posedge clk) disable iff (reset)
        !(port.line_we && port.word_we)
    );

endmodule

// ==== verilog/way_if.sv ====
interface way_if
    import dcache_pkg::*;
#(
    parameter int SETS = 16
) ();

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    // controller to way
    logic [IDX_W-1:0] lk_idx;       // read index sampled every cycle
    logic [TAG_W-1:0] lk_tag;       // tag of the request in the lookup stage
    logic             line_we;      // full line refill
    logic             word_we;      // single word store
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    line_t            wr_line;
    word_sel_t        wr_sel;
    strb_t            wr_strb;
    logic             set_dirty;
    logic             clr_dirty;

    // way to controller
    logic             hit;
    logic             valid;
    logic             dirty;
    logic [TAG_W-1:0] tag;
    line_t            line;

    modport ctrl (
        output lk_idx, lk_tag, line_we, word_we, wr_idx, wr_tag, wr_line,
        output wr_sel, wr_strb, set_dirty, clr_dirty,
        input  hit, valid, dirty, tag, line
    );

    modport way (
        input  lk_idx, lk_tag, line_we, word_we, wr_idx, wr_tag, wr_line,
        input  wr_sel, wr_strb, set_dirty, clr_dirty,
        output hit, valid, dirty, tag, line
    );

endinterface
